//--- alu.sv
`timescale 1ns/100ps

module alu (
    input  rv32i_types::alu_ops    i_op,
    input  rv32i_types::rv32i_word i_a,
    input  rv32i_types::rv32i_word i_b,
    output rv32i_types::rv32i_word o_result
);
    import rv32i_types::*;

    logic [4:0] shamt;

    assign shamt = i_b[4:0]; // shifts use the low five bits only

    always_comb begin
        case (i_op)
            alu_add:  o_result = i_a + i_b;
            alu_sub:  o_result = i_a - i_b;
            alu_sll:  o_result = i_a << shamt;
            alu_slt:  o_result = ($signed(i_a) < $signed(i_b)) ? rv32i_word'(1) : '0;
            alu_sltu: o_result = (i_a < i_b) ? rv32i_word'(1) : '0;
            alu_xor:  o_result = i_a ^ i_b;
            alu_srl:  o_result = i_a >> shamt;
            alu_sra:  o_result = rv32i_word'($signed(i_a) >>> shamt);
            alu_or:   o_result = i_a | i_b;
            alu_and:  o_result = i_a & i_b;
            default:  o_result = '0;
        endcase
    end

endmodule : alu

//--- build.f
+incdir+.
rv32i_types.sv
control_rom.sv
regfile.sv
alu.sv
datapath.sv
rv32i_core.sv
rv32i_core_properties.sv
rv32i_core_tb.sv

//--- control_rom.sv
`timescale 1ns/100ps

module control_rom (
    input  rv32i_types::rv32i_opcode       i_opcode,
    input  logic [2:0]                     i_funct3,
    input  logic [6:0]                     i_funct7,
    input  rv32i_types::rv32i_word         i_instruction,
    output rv32i_types::rv32i_control_word o_ctrl
);
    import rv32i_types::*;

    logic alt_funct7; // selects sub and sra

    assign alt_funct7 = (i_funct7 == 7'b0100000);

    always_comb begin
        // defaults cover a plain pc+4 instruction with nothing written
        o_ctrl                = '0;
        o_ctrl.opcode         = i_opcode;
        o_ctrl.load_pc        = 1'b1;
        o_ctrl.pcmux_sel      = pcmux_pc_plus4;
        o_ctrl.alumux1_sel    = alumux1_rs1_out;
        o_ctrl.alumux2_sel    = alumux2_i_imm;
        o_ctrl.cmpmux_sel     = cmpmux_rs2_out;
        o_ctrl.regfilemux_sel = regfilemux_alu_out;
        o_ctrl.aluop          = alu_add;
        o_ctrl.cmpop          = branch_funct3_t'(i_funct3);
        o_ctrl.store_size     = store_funct3_t'(i_funct3);
        o_ctrl.rd             = i_instruction[11:7];

        case (i_opcode)
            op_lui: begin
                o_ctrl.load_regfile   = 1'b1;
                o_ctrl.regfilemux_sel = regfilemux_u_imm;
            end

            op_auipc: begin
                o_ctrl.alumux1_sel  = alumux1_pc_out;
                o_ctrl.alumux2_sel  = alumux2_u_imm;
                o_ctrl.load_regfile = 1'b1;
            end

            op_jal: begin
                o_ctrl.alumux1_sel    = alumux1_pc_out;
                o_ctrl.alumux2_sel    = alumux2_j_imm;
                o_ctrl.pcmux_sel      = pcmux_alu_out;
                o_ctrl.load_regfile   = 1'b1;
                o_ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end

            op_jalr: begin
                o_ctrl.pcmux_sel      = pcmux_alu_mod2; // rs1 + imm, bit 0 dropped
                o_ctrl.load_regfile   = 1'b1;
                o_ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end

            op_br: begin
                // target from the alu, taken/not taken decided in the datapath
                o_ctrl.alumux1_sel = alumux1_pc_out;
                o_ctrl.alumux2_sel = alumux2_b_imm;
                o_ctrl.use_br_en   = 1'b1;
            end

            op_load: begin
                o_ctrl.mem_read     = 1'b1;
                o_ctrl.load_regfile = 1'b1;
                case (load_funct3_t'(i_funct3))
                    lb:      o_ctrl.regfilemux_sel = regfilemux_lb;
                    lh:      o_ctrl.regfilemux_sel = regfilemux_lh;
                    lw:      o_ctrl.regfilemux_sel = regfilemux_lw;
                    lbu:     o_ctrl.regfilemux_sel = regfilemux_lbu;
                    lhu:     o_ctrl.regfilemux_sel = regfilemux_lhu;
                    default: o_ctrl = '0; // reserved width, treated as illegal
                endcase
            end

            op_store: begin
                o_ctrl.alumux2_sel = alumux2_s_imm;
                o_ctrl.mem_write   = 1'b1;
            end

            op_imm, op_reg: begin
                o_ctrl.load_regfile = 1'b1;
                if (i_opcode == op_reg) begin
                    o_ctrl.alumux2_sel = alumux2_rs2_out;
                end
                case (arith_funct3_t'(i_funct3))
                    slt, sltu: begin
                        // result is the comparator bit
                        o_ctrl.cmpop          = (i_funct3 == slt) ? blt : bltu;
                        o_ctrl.regfilemux_sel = regfilemux_br_en;
                        if (i_opcode == op_imm) begin
                            o_ctrl.cmpmux_sel = cmpmux_i_imm;
                        end
                    end
                    add: begin
                        // addi has no sub form, imm bits would look like funct7
                        if (i_opcode == op_reg && alt_funct7) begin
                            o_ctrl.aluop = alu_sub;
                        end else begin
                            o_ctrl.aluop = alu_add;
                        end
                    end
                    sr: o_ctrl.aluop = alt_funct7 ? alu_sra : alu_srl;
                    default: o_ctrl.aluop = alu_ops'({1'b0, i_funct3});
                endcase
            end

            op_csr: begin
                o_ctrl = '0; // no csr support, core parks here
            end

            default: begin
                o_ctrl = '0; // unknown opcode
            end
        endcase
    end

endmodule : control_rom

//--- datapath.sv
`timescale 1ns/100ps

`include "rv32i_consts.svh"

module datapath (
    input  logic                           clk,
    input  logic                           i_rst,
    input  rv32i_types::rv32i_control_word i_ctrl,
    input  rv32i_types::rv32i_word         i_instr,
    input  rv32i_types::rv32i_word         i_dmem_rdata,
    output rv32i_types::rv32i_opcode       o_opcode,
    output logic [2:0]                     o_funct3,
    output logic [6:0]                     o_funct7,
    output rv32i_types::rv32i_word         o_pc,
    output rv32i_types::rv32i_dmem_req     o_dmem,
    output rv32i_types::rv32i_retire       o_retire
);
    import rv32i_types::*;

    rv32i_word  pc, pc_plus4, pc_next;
    rv32i_word  imm_i, imm_s, imm_b, imm_u, imm_j;
    rv32i_word  rs1_data, rs2_data;
    rv32i_word  alu_a, alu_b, alu_result, cmp_b;
    rv32i_word  wb_data, st_data;
    logic [3:0] st_mask;
    logic [7:0] ld_byte;
    logic [15:0] ld_half;
    logic       br_en;

    assign o_opcode = rv32i_opcode'(i_instr[6:0]);
    assign o_funct3 = i_instr[14:12];
    assign o_funct7 = i_instr[31:25];

    // immediates, all sign extended from bit 31 except u
    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'h000};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    regfile u_regfile (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_load     (i_ctrl.load_regfile),
        .i_rd       (i_ctrl.rd),
        .i_rs1      (i_instr[19:15]),
        .i_rs2      (i_instr[24:20]),
        .i_data     (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign alu_a = (i_ctrl.alumux1_sel == alumux1_pc_out) ? pc : rs1_data;

    always_comb begin
        case (i_ctrl.alumux2_sel)
            alumux2_u_imm:   alu_b = imm_u;
            alumux2_b_imm:   alu_b = imm_b;
            alumux2_s_imm:   alu_b = imm_s;
            alumux2_j_imm:   alu_b = imm_j;
            alumux2_rs2_out: alu_b = rs2_data;
            default:         alu_b = imm_i;
        endcase
    end

    alu u_alu (
        .i_op     (i_ctrl.aluop),
        .i_a      (alu_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    // comparator, shared by branches and slt/sltu
    assign cmp_b = (i_ctrl.cmpmux_sel == cmpmux_i_imm) ? imm_i : rs2_data;

    always_comb begin
        case (i_ctrl.cmpop)
            beq:     br_en = (rs1_data == cmp_b);
            bne:     br_en = (rs1_data != cmp_b);
            blt:     br_en = ($signed(rs1_data) < $signed(cmp_b));
            bge:     br_en = ($signed(rs1_data) >= $signed(cmp_b));
            bltu:    br_en = (rs1_data < cmp_b);
            bgeu:    br_en = (rs1_data >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (i_ctrl.use_br_en && br_en) begin
            pc_next = alu_result; // taken branch
        end else begin
            case (i_ctrl.pcmux_sel)
                pcmux_alu_out:  pc_next = alu_result;
                pcmux_alu_mod2: pc_next = {alu_result[31:1], 1'b0};
                default:        pc_next = pc_plus4;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= `RV32I_RESET_PC;
        end else if (i_ctrl.load_pc) begin // held on a zero control word
            pc <= pc_next;
        end
    end

    // load lanes picked by the low address bits
    assign ld_byte = i_dmem_rdata[{alu_result[1:0], 3'b000} +: 8];
    assign ld_half = alu_result[1] ? i_dmem_rdata[31:16] : i_dmem_rdata[15:0];

    // store data replicated across lanes, mask picks the live ones
    always_comb begin
        case (i_ctrl.store_size)
            sb: begin
                st_data = {4{rs2_data[7:0]}};
                st_mask = 4'b0001 << alu_result[1:0];
            end
            sh: begin
                st_data = {2{rs2_data[15:0]}};
                st_mask = alu_result[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data = rs2_data;
                st_mask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        case (i_ctrl.regfilemux_sel)
            regfilemux_br_en:    wb_data = {31'b0, br_en};
            regfilemux_u_imm:    wb_data = imm_u;
            regfilemux_pc_plus4: wb_data = pc_plus4;
            regfilemux_lb:       wb_data = {{24{ld_byte[7]}}, ld_byte};
            regfilemux_lbu:      wb_data = {24'b0, ld_byte};
            regfilemux_lh:       wb_data = {{16{ld_half[15]}}, ld_half};
            regfilemux_lhu:      wb_data = {16'b0, ld_half};
            regfilemux_lw:       wb_data = i_dmem_rdata;
            default:             wb_data = alu_result;
        endcase
    end

    assign o_pc = pc;

    assign o_dmem.addr  = {alu_result[31:2], 2'b00};
    assign o_dmem.wdata = st_data;
    assign o_dmem.mask  = st_mask;
    assign o_dmem.read  = i_ctrl.mem_read & ~i_rst;  // no strobes in reset
    assign o_dmem.write = i_ctrl.mem_write & ~i_rst;

    // value that lands in rd at the next edge, x0 included
    assign o_retire.valid = i_ctrl.load_regfile & ~i_rst;
    assign o_retire.pc    = pc;
    assign o_retire.rd    = i_ctrl.rd;
    assign o_retire.data  = wb_data;

endmodule : datapath

//--- regfile.sv
`timescale 1ns/100ps

`include "rv32i_consts.svh"

module regfile (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_load,
    input  rv32i_types::rv32i_reg  i_rd,
    input  rv32i_types::rv32i_reg  i_rs1,
    input  rv32i_types::rv32i_reg  i_rs2,
    input  rv32i_types::rv32i_word i_data,
    output rv32i_types::rv32i_word o_rs1_data,
    output rv32i_types::rv32i_word o_rs2_data
);
    import rv32i_types::*;

    rv32i_word regs [`RV32I_NUM_REGS];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV32I_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_load && i_rd != '0) begin // x0 writes dropped
            regs[i_rd] <= i_data;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule : regfile

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv32i_core_tb -f build.f -o rv32i_sim

./obj_dir/rv32i_sim | tee sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
else
    exit 1
fi

//--- rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// architectural data width
`define RV32I_XLEN      32

// x0..x31
`define RV32I_NUM_REGS  32

// first fetch address after reset
`define RV32I_RESET_PC  32'h0000_0000

`endif

//--- rv32i_core.sv
`timescale 1ns/100ps

module rv32i_core (
    input  logic                       clk,
    input  logic                       i_rst,
    input  rv32i_types::rv32i_word     i_instr,
    input  rv32i_types::rv32i_word     i_dmem_rdata,
    output rv32i_types::rv32i_word     o_pc,
    output rv32i_types::rv32i_dmem_req o_dmem,
    output rv32i_types::rv32i_retire   o_retire
);
    import rv32i_types::*;

    rv32i_control_word ctrl;
    rv32i_opcode       opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    control_rom u_control_rom (
        .i_opcode      (opcode),
        .i_funct3      (funct3),
        .i_funct7      (funct7),
        .i_instruction (i_instr),
        .o_ctrl        (ctrl)
    );

    datapath u_datapath (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_ctrl       (ctrl),
        .i_instr      (i_instr),
        .i_dmem_rdata (i_dmem_rdata),
        .o_opcode     (opcode),
        .o_funct3     (funct3),
        .o_funct7     (funct7),
        .o_pc         (o_pc),
        .o_dmem       (o_dmem),
        .o_retire     (o_retire)
    );

endmodule : rv32i_core

//--- rv32i_core_properties.sv
`timescale 1ns/100ps

module rv32i_core_properties (
    input logic                       clk,
    input logic                       i_rst,
    input rv32i_types::rv32i_word     i_instr,
    input rv32i_types::rv32i_word     o_pc,
    input rv32i_types::rv32i_dmem_req o_dmem,
    input rv32i_types::rv32i_retire   o_retire
);
    import rv32i_types::*;

    logic known_op;

    assign known_op = i_instr[6:0] inside {op_lui, op_auipc, op_jal, op_jalr, op_br,
                                           op_load, op_store, op_imm, op_reg};

    rd_wr_exclusive: assert property (@(posedge clk) !(o_dmem.read && o_dmem.write))
        else $error("data memory read and write raised together");

    pc_even: assert property (@(posedge clk) disable iff (i_rst) o_pc[0] == 1'b0)
        else $error("pc bit 0 is set");

    quiet_in_reset: assert property (@(posedge clk)
        i_rst |-> !o_dmem.read && !o_dmem.write && !o_retire.valid)
        else $error("strobe active during reset");

    // unknown opcodes must never write a register
    no_retire_unknown: assert property (@(posedge clk) !known_op |-> !o_retire.valid)
        else $error("retire on an unknown opcode");

endmodule : rv32i_core_properties

bind rv32i_core rv32i_core_properties u_props (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_instr  (i_instr),
    .o_pc     (o_pc),
    .o_dmem   (o_dmem),
    .o_retire (o_retire)
);

//--- rv32i_core_tb.sv
`timescale 1ns/100ps

`include "rv32i_consts.svh"

module rv32i_core_tb;
    import rv32i_types::*;

    logic          clk = 1'b0;
    logic          i_rst;
    rv32i_word     i_instr, i_dmem_rdata, o_pc;
    rv32i_dmem_req o_dmem;
    rv32i_retire   o_retire;

    rv32i_word imem [256];
    rv32i_word dmem [256];     // what the DUT sees
    rv32i_word m_dmem [256];   // model copy
    rv32i_word m_regs [32];
    rv32i_word m_pc;
    integer    seed, errors, checks, test_start;

    // model prediction for the current instruction
    logic       e_valid, e_read, e_write, halted;
    rv32i_reg   e_rd;
    rv32i_word  e_data, e_addr, e_wdata, e_next;
    logic [3:0] e_mask;

    // store seen on the DUT port and applied after the edge
    logic       st_we;
    logic [7:0] st_idx;
    logic [3:0] st_mask;
    rv32i_word  st_data;

    always #10 clk = ~clk;

    // combinational memories
    assign i_instr      = imem[o_pc[9:2]];
    assign i_dmem_rdata = dmem[o_dmem.addr[9:2]];

    rv32i_core u_dut (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_instr      (i_instr),
        .i_dmem_rdata (i_dmem_rdata),
        .o_pc         (o_pc),
        .o_dmem       (o_dmem),
        .o_retire     (o_retire)
    );

    function automatic rv32i_word next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic rv32i_reg pick_reg();
        rv32i_word r;
        r = next_rand();
        pick_reg = {2'b00, r[2:0]}; // x0..x7 keeps dependencies dense
    endfunction

    function automatic rv32i_word enc_r(logic [6:0] f7, rv32i_reg rs2, rv32i_reg rs1,
                                        logic [2:0] f3, rv32i_reg rd);
        enc_r = {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic rv32i_word enc_i(logic [11:0] imm, rv32i_reg rs1, logic [2:0] f3,
                                        rv32i_reg rd, logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv32i_word enc_s(logic [11:0] imm, rv32i_reg rs2, rv32i_reg rs1,
                                        logic [2:0] f3);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic rv32i_word enc_b(logic [12:0] imm, rv32i_reg rs2, rv32i_reg rs1,
                                        logic [2:0] f3);
        enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic rv32i_word enc_j(logic [20:0] imm, rv32i_reg rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // lui, auipc, op_imm or op_reg with legal funct7 fields
    function automatic rv32i_word arith_instr();
        rv32i_word  r, s;
        logic [2:0] f3;
        r  = next_rand();
        s  = next_rand();
        f3 = r[6:4];
        case (r[1:0])
            2'd0: arith_instr = {s[31:12], pick_reg(), 7'h37};
            2'd1: arith_instr = {s[31:12], pick_reg(), 7'h17};
            2'd2: begin
                if (f3 == 3'd1)
                    arith_instr = enc_i({7'h00, s[4:0]}, pick_reg(), f3, pick_reg(), 7'h13);
                else if (f3 == 3'd5)
                    arith_instr = enc_i({r[8] ? 7'h20 : 7'h00, s[4:0]}, pick_reg(), f3,
                                        pick_reg(), 7'h13);
                else
                    arith_instr = enc_i(s[11:0], pick_reg(), f3, pick_reg(), 7'h13);
            end
            default: arith_instr = enc_r((r[8] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                         pick_reg(), pick_reg(), f3, pick_reg());
        endcase
    endfunction

    function automatic rv32i_word illegal_word();
        rv32i_word r;
        r = next_rand();
        illegal_word = r[0] ? 32'h0000_0073 : {r[31:7], 7'b0001011}; // ecall or custom-0
    endfunction

    task automatic build_arith_prog(input integer len);
        for (int i = 0; i < len - 1; i++) imem[i] = arith_instr();
        imem[len-1] = illegal_word();
    endtask

    task automatic build_mem_prog(input integer len);
        logic [2:0] ld_f3 [5];
        rv32i_word  r;
        ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        for (int i = 0; i < len - 1; i++) begin
            r = next_rand();
            case ($unsigned(r) % 3)
                0: imem[i] = arith_instr();
                1: imem[i] = enc_i(r[31:20], pick_reg(), ld_f3[$unsigned(r[15:8]) % 5],
                                   pick_reg(), 7'h03);
                default: imem[i] = enc_s(r[31:20], pick_reg(), pick_reg(),
                                         3'($unsigned(r[15:8]) % 3));
            endcase
        end
        imem[len-1] = illegal_word();
    endtask

    // forward-only control flow so every program reaches its last word
    task automatic build_flow_prog(input integer len);
        logic [2:0] br_f3 [6];
        rv32i_word  r;
        integer     tgt;
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int i = 0; i < len - 1; i++) begin
            r   = next_rand();
            tgt = i + 1 + r[9:8];
            if (tgt > len - 1) tgt = len - 1;
            case (r[1:0])
                2'd0: imem[i] = arith_instr();
                2'd1: imem[i] = enc_b(13'(4 * (tgt - i)), pick_reg(), pick_reg(),
                                      br_f3[$unsigned(r[15:8]) % 6]);
                2'd2: imem[i] = enc_j(21'(4 * (tgt - i)), pick_reg());
                default: imem[i] = enc_i(12'(4 * tgt + r[4]), 5'd0, 3'd0, pick_reg(), 7'h67);
            endcase
        end
        imem[len-1] = illegal_word();
    endtask

    task automatic predict();
        rv32i_word  ins, a, b, op2, imm_i, imm_s, imm_b, imm_j, imm_u, word;
        logic [2:0] f3;
        logic       take, alt;
        logic [7:0] bt;
        logic [15:0] hf;
        ins   = imem[m_pc[9:2]];
        f3    = ins[14:12];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        {e_valid, e_read, e_write, halted} = 4'b0000;
        e_rd = ins[11:7];
        {e_data, e_addr, e_wdata} = '0;
        e_mask = 4'b0000;
        e_next = m_pc + 32'd4;
        case (ins[6:0])
            7'h37: {e_valid, e_data} = {1'b1, imm_u};
            7'h17: {e_valid, e_data} = {1'b1, m_pc + imm_u};
            7'h6f: begin
                {e_valid, e_data} = {1'b1, m_pc + 32'd4};
                e_next = m_pc + imm_j;
            end
            7'h67: begin
                {e_valid, e_data} = {1'b1, m_pc + 32'd4};
                e_next = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    default: take = (a >= b);
                endcase
                if (take) e_next = m_pc + imm_b;
            end
            7'h03: begin
                e_addr = a + imm_i;
                word   = m_dmem[e_addr[9:2]];
                bt     = 8'(word >> (8 * e_addr[1:0]));
                hf     = e_addr[1] ? word[31:16] : word[15:0];
                {e_valid, e_read} = 2'b11;
                case (f3)
                    3'd0: e_data = {{24{bt[7]}}, bt};
                    3'd1: e_data = {{16{hf[15]}}, hf};
                    3'd4: e_data = {24'h0, bt};
                    3'd5: e_data = {16'h0, hf};
                    default: e_data = word;
                endcase
            end
            7'h23: begin
                e_addr  = a + imm_s;
                e_write = 1'b1;
                case (f3)
                    3'd0: begin
                        e_mask  = 4'b0001 << e_addr[1:0];
                        e_wdata = {24'h0, b[7:0]} << (8 * e_addr[1:0]);
                    end
                    3'd1: begin
                        e_mask  = e_addr[1] ? 4'b1100 : 4'b0011;
                        e_wdata = {16'h0, b[15:0]} << (e_addr[1] ? 16 : 0);
                    end
                    default: {e_mask, e_wdata} = {4'b1111, b};
                endcase
            end
            7'h13, 7'h33: begin
                op2     = (ins[6:0] == 7'h13) ? imm_i : b;
                alt     = ins[30] && (ins[6:0] == 7'h33 || f3 == 3'd5);
                e_valid = 1'b1;
                case (f3)
                    3'd0: e_data = alt ? a - op2 : a + op2;
                    3'd1: e_data = a << op2[4:0];
                    3'd2: e_data = {31'h0, $signed(a) < $signed(op2)};
                    3'd3: e_data = {31'h0, a < op2};
                    3'd4: e_data = a ^ op2;
                    3'd5: e_data = alt ? $unsigned($signed(a) >>> op2[4:0]) : a >> op2[4:0];
                    3'd6: e_data = a | op2;
                    default: e_data = a & op2;
                endcase
            end
            default: begin
                halted = 1'b1; // core parks on this word
                e_next = m_pc;
            end
        endcase
    endtask

    task automatic check_word(input string name, input rv32i_word got, input rv32i_word exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs();
        rv32i_word lanes;
        lanes = {{8{e_mask[3]}}, {8{e_mask[2]}}, {8{e_mask[1]}}, {8{e_mask[0]}}};
        check_word("o_pc", o_pc, m_pc);
        check_word("o_retire.valid", 32'(o_retire.valid), 32'(e_valid));
        if (e_valid) begin
            check_word("o_retire.rd", 32'(o_retire.rd), 32'(e_rd));
            check_word("o_retire.pc", o_retire.pc, m_pc);
            check_word("o_retire.data", o_retire.data, e_data);
        end
        check_word("o_dmem.read", 32'(o_dmem.read), 32'(e_read));
        check_word("o_dmem.write", 32'(o_dmem.write), 32'(e_write));
        if (e_read || e_write) check_word("o_dmem.addr", o_dmem.addr, e_addr & ~32'd3);
        if (e_write) begin
            check_word("o_dmem.mask", 32'(o_dmem.mask), 32'(e_mask));
            check_word("o_dmem.wdata", o_dmem.wdata & lanes, e_wdata & lanes);
        end
        st_we   = o_dmem.write;
        st_idx  = o_dmem.addr[9:2];
        st_mask = o_dmem.mask;
        st_data = o_dmem.wdata;
    endtask

    task automatic commit();
        for (int k = 0; k < 4; k++) begin
            if (st_we && st_mask[k]) dmem[st_idx][8*k +: 8] = st_data[8*k +: 8];
            if (e_write && e_mask[k]) m_dmem[e_addr[9:2]][8*k +: 8] = e_wdata[8*k +: 8];
        end
        if (e_valid && e_rd != 5'd0) m_regs[e_rd] = e_data;
        m_pc = e_next;
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s", what);
        errors++;
    endtask

    task automatic reset_core();
        @(posedge clk);
        #1 i_rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_word("o_retire.valid", 32'(o_retire.valid), 32'd0);
        check_word("o_dmem.read", 32'(o_dmem.read), 32'd0);
        check_word("o_dmem.write", 32'(o_dmem.write), 32'd0);
        @(posedge clk);
        #1 i_rst = 1'b0;
        m_pc = `RV32I_RESET_PC;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        for (int i = 0; i < 256; i++) m_dmem[i] = dmem[i];
    endtask

    // step until the model parks on the illegal word
    task automatic run_program(input integer max_cycles);
        integer n;
        n = 0;
        halted = 1'b0;
        while (!halted && n < max_cycles) begin
            predict();
            @(negedge clk);
            check_outputs();
            if (!halted) begin
                @(posedge clk);
                #1 commit();
            end
            n++;
        end
        if (!halted) fail_timeout("program never reached its final word");
    endtask

    task automatic report(input string name);
        $display("%-24s %s (%0d errors)", name, (errors == test_start) ? "ok" : "FAILED",
                 errors - test_start);
        test_start = errors;
    endtask

    initial begin
        seed   = 32'h03ff9afb;
        errors = 0;
        checks = 0;
        test_start = 0;
        i_rst  = 1'b1;
        for (int i = 0; i < 256; i++) begin
            imem[i] = next_rand();
            dmem[i] = next_rand();
        end

        build_arith_prog(48);
        reset_core();
        check_word("o_pc", o_pc, `RV32I_RESET_PC);
        report("reset");

        run_program(200);
        report("arith and upper imm");

        build_mem_prog(64);
        reset_core();
        run_program(200);
        report("loads and stores");

        build_flow_prog(64);
        reset_core();
        run_program(200);
        report("branches and jumps");

        build_arith_prog(16);
        reset_core();
        run_program(100);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_word("o_pc", o_pc, m_pc);
            check_word("o_retire.valid", 32'(o_retire.valid), 32'd0);
            check_word("o_dmem.read", 32'(o_dmem.read), 32'd0);
            check_word("o_dmem.write", 32'(o_dmem.write), 32'd0);
        end
        // reset taken while still parked, new program loaded behind it
        reset_core();
        build_arith_prog(16);
        check_word("o_pc", o_pc, `RV32I_RESET_PC);
        run_program(100);
        report("illegal hold and recover");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : rv32i_core_tb

//--- rv32i_types.sv
`include "rv32i_consts.svh"

package rv32i_types;

    typedef logic [`RV32I_XLEN-1:0] rv32i_word;
    typedef logic [4:0]             rv32i_reg;

    // major opcodes, bits 6..0 of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000, // add or sub, funct7 decides
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // srl or sra
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    // low eight codes line up with funct3
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sll  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_xor  = 4'd4,
        alu_srl  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_sub  = 4'd8,
        alu_sra  = 4'd9
    } alu_ops;

    typedef enum logic [1:0] {
        pcmux_pc_plus4,
        pcmux_alu_out,
        pcmux_alu_mod2 // jalr target, bit 0 cleared
    } pcmux_sel_t;

    typedef enum logic [1:0] {
        alumux1_rs1_out,
        alumux1_pc_out
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm,
        alumux2_u_imm,
        alumux2_b_imm,
        alumux2_s_imm,
        alumux2_j_imm,
        alumux2_rs2_out
    } alumux2_sel_t;

    typedef enum logic [1:0] {
        cmpmux_rs2_out,
        cmpmux_i_imm
    } cmpmux_sel_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out,
        regfilemux_br_en,
        regfilemux_u_imm,
        regfilemux_pc_plus4,
        regfilemux_lb,
        regfilemux_lbu,
        regfilemux_lh,
        regfilemux_lhu,
        regfilemux_lw
    } regfilemux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        logic            load_pc;
        logic            load_regfile;
        logic            use_br_en;      // pc takes the target only when br_en
        pcmux_sel_t      pcmux_sel;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        cmpmux_sel_t     cmpmux_sel;
        regfilemux_sel_t regfilemux_sel;
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        logic            mem_read;
        logic            mem_write;
        store_funct3_t   store_size;
        rv32i_reg        rd;
    } rv32i_control_word;

    typedef struct packed {
        rv32i_word  addr;  // word aligned
        rv32i_word  wdata;
        logic [3:0] mask;
        logic       read;
        logic       write;
    } rv32i_dmem_req;

    typedef struct packed {
        logic      valid;
        rv32i_word pc;
        rv32i_reg  rd;
        rv32i_word data;
    } rv32i_retire;

endpackage
